// ==== rtl/cpu_pkg.sv ====
// ==========================================================================
// cpu_pkg
// Shared types, opcodes, controller states and address constants for the
// 16-bit multi-cycle processor
// ==========================================================================
package cpu_pkg;

    typedef logic signed [15:0] word_t;

    // opcodes 5 to 7 have no name and retire as no-ops
    typedef enum logic [2:0] {
        OP_ALU     = 3'd0,
        OP_CMP_MUL = 3'd1,
        OP_LOAD    = 3'd2,
        OP_STORE   = 3'd3,
        OP_BEQ     = 3'd4
    } opcode_e;

    typedef enum logic [3:0] {
        S_FETCH,
        S_REFILL_REQ,
        S_REFILL_ACK,
        S_DECODE,
        S_EXEC,
        S_MEM_REQ,
        S_MEM_ACK,
        S_WB,
        S_RETIRE
    } state_e;

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            opcode_e    opcode;
            logic [3:0] rs;
            logic [3:0] rt;
            logic [3:0] rd;
            logic       func;
        } r;
        struct packed {
            opcode_e           opcode;
            logic [3:0]        rs;
            logic [3:0]        rt;
            logic signed [4:0] imm;
        } i;
    } inst_t;

    localparam word_t INST_BASE = 16'h1000;
    localparam word_t DATA_BASE = 16'h1000;
    localparam int    REG_COUNT = 16;

endpackage

// ==== rtl/cpu_ctrl.sv ====
// ==========================================================================
// cpu_ctrl
// Processor sequencer: fetch, refill, decode, execute, memory and writeback
// ==========================================================================
`timescale 1ns/1ns

module cpu_ctrl import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    line_hit,
    input  logic    refill_done,
    input  opcode_e opcode,
    input  logic    imem_ack,
    input  logic    dmem_ack,
    output state_e  state,
    output logic    imem_req,
    output logic    dmem_req,
    output logic    dmem_we,
    output logic    io_stall
);

    state_e state_nxt;
    // second cycle of a hit fetch
    logic   fetch_cnt;

    // ======================================================================
    // state register
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_FETCH;
            fetch_cnt <= 1'b0;
            io_stall  <= 1'b1;
        end else begin
            state     <= state_nxt;
            fetch_cnt <= (state == S_FETCH) && line_hit && !fetch_cnt;
            // low for exactly the retire cycle
            io_stall  <= (state_nxt != S_RETIRE);
        end
    end

    // ======================================================================
    // next state
    // ======================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            S_FETCH: begin
                if (!line_hit) begin
                    state_nxt = S_REFILL_REQ;
                end else if (fetch_cnt) begin
                    state_nxt = S_DECODE;
                end
            end
            S_REFILL_REQ: begin
                if (imem_ack) state_nxt = S_REFILL_ACK;
            end
            S_REFILL_ACK: begin
                // wait for ack to drop before the next word or the fetch
                if (!imem_ack) state_nxt = refill_done ? S_FETCH : S_REFILL_REQ;
            end
            S_DECODE: state_nxt = S_EXEC;
            S_EXEC: begin
                case (opcode)
                    OP_ALU, OP_CMP_MUL: state_nxt = S_WB;
                    OP_LOAD, OP_STORE:  state_nxt = S_MEM_REQ;
                    // beq and the unused opcodes
                    default:            state_nxt = S_RETIRE;
                endcase
            end
            S_MEM_REQ: begin
                if (dmem_ack) state_nxt = S_MEM_ACK;
            end
            S_MEM_ACK: begin
                if (!dmem_ack) state_nxt = (opcode == OP_LOAD) ? S_WB : S_RETIRE;
            end
            S_WB:     state_nxt = S_RETIRE;
            S_RETIRE: state_nxt = S_FETCH;
            default:  state_nxt = S_FETCH;
        endcase
    end

    // four-phase requests straight from the state
    assign imem_req = (state == S_REFILL_REQ);
    assign dmem_req = (state == S_MEM_REQ);
    assign dmem_we  = (state == S_MEM_REQ) && (opcode == OP_STORE);

    // a request is held until its ack arrives
    a_imem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && !imem_ack |=> imem_req);
    a_dmem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req && !dmem_ack |=> dmem_req && $stable(dmem_we));

endmodule

// ==== rtl/refill_counter.sv ====
// ==========================================================================
// refill_counter
// Resident line tag, refill word counter and refill byte address
// ==========================================================================
`timescale 1ns/1ns

module refill_counter import cpu_pkg::*; #(
    parameter  int LINE_WORDS = 32,
    localparam int IDX_W      = $clog2(LINE_WORDS),
    localparam int OFF_W      = IDX_W + 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  state_e           state,
    input  word_t            pc,
    input  logic             imem_ack,
    output logic             line_hit,
    output logic [IDX_W-1:0] word_index,
    output logic             refill_done,
    output logic [15:0]      imem_addr
);

    logic [15-OFF_W:0] tag;
    logic              valid;
    logic              ack_rise;

    // ack seen while req is still high
    assign ack_rise  = (state == S_REFILL_REQ) && imem_ack;
    assign line_hit  = valid && (tag == pc[15:OFF_W]);
    assign imem_addr = {tag, word_index, 1'b0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag         <= '0;
            valid       <= 1'b0;
            word_index  <= '0;
            refill_done <= 1'b0;
        end else begin
            if (state == S_FETCH) begin
                refill_done <= 1'b0;
                // miss: claim the line at the pc before the first req
                if (!line_hit) begin
                    tag   <= pc[15:OFF_W];
                    valid <= 1'b0;
                end
            end
            if (ack_rise) begin
                word_index <= word_index + 1'b1;
                if (&word_index) begin
                    refill_done <= 1'b1;
                    valid       <= 1'b1;
                end
            end
        end
    end

    // no word beyond the line is ever acknowledged, so the index cannot wrap
    a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        ack_rise |-> !refill_done);

endmodule

// ==== rtl/inst_buffer.sv ====
// ==========================================================================
// inst_buffer
// Instruction line memory with registered read, and the instruction register
// ==========================================================================
`timescale 1ns/1ns

module inst_buffer import cpu_pkg::*; #(
    parameter  int LINE_WORDS = 32,
    localparam int IDX_W      = $clog2(LINE_WORDS)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  state_e           state,
    input  logic [IDX_W-1:0] word_index,
    input  logic             imem_ack,
    input  word_t            imem_rdata,
    input  word_t            pc,
    output inst_t            inst
);

    word_t            line_mem [LINE_WORDS];
    word_t            rd_data;
    logic [IDX_W-1:0] rd_idx;

    // word offset of the pc inside its line
    assign rd_idx = pc[IDX_W:1];

    // line memory, one cycle read latency
    always_ff @(posedge clk) begin
        if ((state == S_REFILL_REQ) && imem_ack) begin
            line_mem[word_index] <= imem_rdata;
        end
        if (state == S_FETCH) begin
            rd_data <= line_mem[rd_idx];
        end
    end

    // loaded every fetch cycle, holds the pc word after the second one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst <= '0;
        end else if (state == S_FETCH) begin
            inst <= rd_data;
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
// ==========================================================================
// reg_file
// Sixteen general registers, two registered read ports, one write port
// ==========================================================================
`timescale 1ns/1ns

module reg_file import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  state_e state,
    input  inst_t  inst,
    input  word_t  wb_data,
    output word_t  rs_data,
    output word_t  rt_data
);

    word_t      regs [REG_COUNT];
    logic [3:0] wr_sel;

    // load writes rt, the ALU ops write rd
    assign wr_sel = (inst.i.opcode == OP_LOAD) ? inst.i.rt : inst.r.rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (state == S_WB) begin
            regs[wr_sel] <= wb_data;
        end
    end

    // operand capture in decode
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            rs_data <= regs[inst.r.rs];
            rt_data <= regs[inst.r.rt];
        end
    end

endmodule

// ==== rtl/exec_unit.sv ====
// ==========================================================================
// exec_unit
// ALU, branch and pc update, data address and the writeback result
// ==========================================================================
`timescale 1ns/1ns

module exec_unit import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  state_e state,
    input  inst_t  inst,
    input  word_t  rs_data,
    input  word_t  rt_data,
    input  logic   dmem_ack,
    input  word_t  dmem_rdata,
    output word_t  pc,
    output word_t  wb_data,
    output word_t  dmem_addr,
    output word_t  dmem_wdata
);

    word_t imm_ext;
    word_t alu_res;
    logic  taken;

    assign imm_ext = {{11{inst.i.imm[4]}}, inst.i.imm};
    assign taken   = (inst.i.opcode == OP_BEQ) && (rs_data == rt_data);

    // ======================================================================
    // ALU
    // ======================================================================
    always_comb begin
        case (inst.r.opcode)
            // func 1 selects sub
            OP_ALU:     alu_res = inst.r.func ? rs_data - rt_data : rs_data + rt_data;
            // func 1 selects mul, low half only
            OP_CMP_MUL: alu_res = inst.r.func ? rs_data * rt_data : word_t'(rs_data < rt_data);
            default:    alu_res = '0;
        endcase
    end

    // ======================================================================
    // pc, address and result
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= INST_BASE;
        end else if (state == S_EXEC) begin
            pc <= taken ? pc + 16'sd2 + (imm_ext <<< 1) : pc + 16'sd2;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_EXEC) begin
            wb_data   <= alu_res;
            dmem_addr <= ((rs_data + imm_ext) <<< 1) + DATA_BASE;
        end else if ((state == S_MEM_REQ) && dmem_ack && (inst.i.opcode == OP_LOAD)) begin
            // load data replaces the ALU result
            wb_data <= dmem_rdata;
        end
    end

    // store data is the rt operand
    assign dmem_wdata = rt_data;

endmodule

// ==== rtl/cpu_top.sv ====
// ==========================================================================
// cpu_top
// 16-bit multi-cycle processor with instruction and data req/ack ports
// ==========================================================================
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; #(
    parameter int LINE_WORDS = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic        io_stall,
    // instruction port
    output logic        imem_req,
    output logic [15:0] imem_addr,
    input  logic        imem_ack,
    input  word_t       imem_rdata,
    // data port
    output logic        dmem_req,
    output logic        dmem_we,
    output word_t       dmem_addr,
    output word_t       dmem_wdata,
    input  logic        dmem_ack,
    input  word_t       dmem_rdata
);

    localparam int IDX_W = $clog2(LINE_WORDS);

    state_e           state;
    logic             line_hit;
    logic             refill_done;
    logic [IDX_W-1:0] word_index;
    inst_t            inst;
    word_t            pc;
    word_t            rs_data;
    word_t            rt_data;
    word_t            wb_data;

    cpu_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .line_hit    (line_hit),
        .refill_done (refill_done),
        .opcode      (inst.r.opcode),
        .imem_ack    (imem_ack),
        .dmem_ack    (dmem_ack),
        .state       (state),
        .imem_req    (imem_req),
        .dmem_req    (dmem_req),
        .dmem_we     (dmem_we),
        .io_stall    (io_stall)
    );

    refill_counter #(.LINE_WORDS(LINE_WORDS)) u_refill (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .pc          (pc),
        .imem_ack    (imem_ack),
        .line_hit    (line_hit),
        .word_index  (word_index),
        .refill_done (refill_done),
        .imem_addr   (imem_addr)
    );

    inst_buffer #(.LINE_WORDS(LINE_WORDS)) u_ibuf (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .word_index (word_index),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .pc         (pc),
        .inst       (inst)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .state   (state),
        .inst    (inst),
        .wb_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    exec_unit u_exec (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .inst       (inst),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata),
        .pc         (pc),
        .wb_data    (wb_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata)
    );

endmodule

// ==== dv/cpu_ref_model.svh ====
// ==========================================================================
// reference model
// Random program generator and instruction-level model of the processor
// ==========================================================================
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

localparam int    PROG_LEN   = 200;
localparam int    IMEM_WORDS = 256;
localparam word_t LINE_MASK  = word_t'(-(2 * LINE_WORDS));

word_t prog [IMEM_WORDS];
word_t model_mem [word_t];
word_t exp_st_addr [$];
word_t exp_st_data [$];
word_t exp_lines [$];
int    exp_retire;

// data memory contents before any store
function automatic word_t fill_word(word_t addr);
    logic [31:0] h;
    h = {16'h0, addr} * 32'h9e3779b1;
    return word_t'(h[31:16] ^ h[15:0]);
endfunction

function automatic word_t enc_r(opcode_e op, int rs, int rt, int rd, int func);
    inst_t w;
    w.r.opcode = op;
    w.r.rs     = rs[3:0];
    w.r.rt     = rt[3:0];
    w.r.rd     = rd[3:0];
    w.r.func   = func[0];
    return word_t'(w);
endfunction

function automatic word_t enc_i(opcode_e op, int rs, int rt, int imm);
    inst_t w;
    w.i.opcode = op;
    w.i.rs     = rs[3:0];
    w.i.rt     = rt[3:0];
    w.i.imm    = imm[4:0];
    return word_t'(w);
endfunction

task automatic build_program();
    int i;
    int kind;
    int ra;
    int rb;
    int room;
    for (int k = 0; k < IMEM_WORDS; k++) begin
        prog[k] = '0;
    end
    i = 0;
    while (i < PROG_LEN - 1) begin
        kind = rand_range(10);
        ra   = rand_range(REG_COUNT);
        rb   = rand_range(REG_COUNT);
        if (kind < 3) begin
            prog[i] = enc_r(OP_ALU, ra, rb, rand_range(16), rand_range(2));
        end else if (kind < 5) begin
            prog[i] = enc_r(OP_CMP_MUL, ra, rb, rand_range(16), rand_range(2));
        end else if (kind == 5 && i < PROG_LEN - 2) begin
            // load, then store the loaded register elsewhere
            prog[i] = enc_i(OP_LOAD, ra, rb, rand_range(32) - 16);
            i++;
            prog[i] = enc_i(OP_STORE, rand_range(16), rb, rand_range(32) - 16);
        end else if (kind == 6) begin
            prog[i] = enc_i(OP_STORE, ra, rb, rand_range(32) - 16);
        end else if (kind < 9) begin
            // forward only, never past the final loop
            room = PROG_LEN - 2 - i;
            if (room > 15) begin
                room = 15;
            end
            prog[i] = enc_i(OP_BEQ, ra, (rand_range(2) == 1) ? ra : rb, rand_range(room + 1));
        end else begin
            prog[i] = enc_r(opcode_e'(3'(5 + rand_range(3))), ra, rb, rand_range(16), 0);
        end
        i++;
    end
    prog[PROG_LEN-1] = enc_i(OP_BEQ, 0, 0, -1);
endtask

task automatic run_model();
    word_t regs [REG_COUNT];
    word_t pc;
    word_t nxt;
    word_t a;
    word_t b;
    word_t imm;
    word_t addr;
    word_t line;
    inst_t w;
    int    idx;
    for (int k = 0; k < REG_COUNT; k++) begin
        regs[k] = '0;
    end
    pc         = INST_BASE;
    line       = '1;
    exp_retire = 0;
    for (int step = 0; step < PROG_LEN; step++) begin
        // one resident line, so any line change is a refill
        if ((pc & LINE_MASK) != line) begin
            line = pc & LINE_MASK;
            exp_lines.push_back(line);
        end
        idx = (int'(pc) - int'(INST_BASE)) / 2;
        if (idx == PROG_LEN - 1) begin
            break;
        end
        w    = inst_t'(prog[idx]);
        a    = regs[w.r.rs];
        b    = regs[w.r.rt];
        imm  = {{11{w.i.imm[4]}}, w.i.imm};
        addr = ((a + imm) * 16'sd2) + DATA_BASE;
        nxt  = pc + 16'sd2;
        case (w.r.opcode)
            OP_ALU:     regs[w.r.rd] = (w.r.func == 1'b1) ? a - b : a + b;
            OP_CMP_MUL: regs[w.r.rd] = (w.r.func == 1'b1) ? a * b : ((a < b) ? 16'sd1 : 16'sd0);
            OP_LOAD:    regs[w.i.rt] = model_mem.exists(addr) ? model_mem[addr] : fill_word(addr);
            OP_STORE: begin
                model_mem[addr] = b;
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(b);
            end
            OP_BEQ: begin
                if (a == b) begin
                    nxt = pc + 16'sd2 + imm * 16'sd2;
                end
            end
            default: ;
        endcase
        exp_retire++;
        pc = nxt;
    end
endtask

`endif

// ==== dv/cpu_tb.sv ====
// ==========================================================================
// cpu_tb
// Random program regression of the processor against an instruction model
// ==========================================================================
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

    localparam int          LINE_WORDS  = 32;
    localparam logic [31:0] SEED        = 32'hb8eed9e1;
    localparam int          CLK_NS      = 8;
    localparam int          WATCHDOG_NS = 200 * 400 * CLK_NS;
    // retire, two fetch cycles, decode, exec
    localparam int          LOOP_CYCLES = 5;

    logic        clk;
    logic        rst_n;
    logic        io_stall;
    logic        imem_req;
    logic [15:0] imem_addr;
    logic        imem_ack;
    word_t       imem_rdata;
    logic        dmem_req;
    logic        dmem_we;
    word_t       dmem_addr;
    word_t       dmem_wdata;
    logic        dmem_ack;
    word_t       dmem_rdata;

    logic [31:0] lcg_state;
    int          imem_wait;
    int          dmem_wait;
    int          refill_pos;
    word_t       refill_next;
    word_t       resp_mem [word_t];
    int          retire_cnt;
    int          cycle_cnt;
    int          last_retire;
    logic        prev_stall;
    logic        loop_entered;

    function automatic int rand_range(int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:16]) % n;
    endfunction

    `include "cpu_ref_model.svh"

    // address of the closing BEQ r0,r0,-1
    localparam word_t LOOP_PC = INST_BASE + word_t'(2 * (PROG_LEN - 1));

    cpu_top #(.LINE_WORDS(LINE_WORDS)) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .io_stall   (io_stall),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // ======================================================================
    // reporting and compare tasks
    // ======================================================================
    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(string msg);
        abort_run($sformatf("[ERROR] t=%0t %s", $time, msg));
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_count(string what, int got, int exp);
        if (got != exp) begin
            report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_store(word_t addr, word_t data);
        if (exp_st_addr.size() == 0) begin
            report_error($sformatf("store of %h to %h beyond the model's stores", data, addr));
        end else begin
            check_word("store address", addr, exp_st_addr.pop_front());
            check_word("store data", data, exp_st_data.pop_front());
        end
    endtask

    function automatic word_t inst_word(logic [15:0] addr);
        int idx;
        idx = (int'(addr) - int'(INST_BASE)) / 2;
        return (idx >= 0 && idx < IMEM_WORDS) ? prog[idx] : '0;
    endfunction

    // ======================================================================
    // memory responders
    // ======================================================================
    // instruction port, also follows the refill address order
    always @(posedge clk) begin
        if (imem_ack) begin
            if (!imem_req) imem_ack <= 1'b0;
        end else if (imem_req) begin
            if (imem_wait > 0) begin
                imem_wait <= imem_wait - 1;
            end else begin
                if (refill_pos == 0) begin
                    if (exp_lines.size() == 0) begin
                        abort_run("a refill started for a line the model never enters");
                    end else begin
                        refill_next = exp_lines.pop_front();
                    end
                end
                check_word("refill address", imem_addr, refill_next);
                refill_next = refill_next + 16'sd2;
                refill_pos  = (refill_pos + 1) % LINE_WORDS;
                imem_rdata <= inst_word(imem_addr);
                imem_ack   <= 1'b1;
                imem_wait  <= rand_range(4);
            end
        end
    end

    always @(posedge clk) begin
        if (dmem_ack) begin
            if (!dmem_req) dmem_ack <= 1'b0;
        end else if (dmem_req) begin
            if (dmem_wait > 0) begin
                dmem_wait <= dmem_wait - 1;
            end else begin
                if (dmem_we) begin
                    check_store(dmem_addr, dmem_wdata);
                    resp_mem[dmem_addr] = dmem_wdata;
                end else begin
                    dmem_rdata <= resp_mem.exists(dmem_addr) ? resp_mem[dmem_addr]
                                                             : fill_word(dmem_addr);
                end
                dmem_ack  <= 1'b1;
                dmem_wait <= rand_range(4);
            end
        end
    end

    // retirement pulses on io_stall
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (rst_n) begin
            if (!io_stall && !prev_stall) begin
                abort_run("io_stall stayed low for more than one cycle");
            end
            if (!io_stall) begin
                retire_cnt  <= retire_cnt + 1;
                last_retire <= cycle_cnt;
                // the retiring instruction has already stepped the pc
                if (!loop_entered && DUT.pc == LOOP_PC) begin
                    check_count("retirements when the final loop is reached",
                                retire_cnt + 1, exp_retire);
                    loop_entered <= 1'b1;
                end
            end
            prev_stall <= io_stall;
        end
    end

    // ======================================================================
    // stimulus and end of run
    // ======================================================================
    initial begin
        int start;
        int loop_prev;
        clk         = 1'b0;
        rst_n      <= 1'b0;
        imem_ack   <= 1'b0;
        imem_rdata <= '0;
        dmem_ack   <= 1'b0;
        dmem_rdata <= '0;
        imem_wait  <= 0;
        dmem_wait  <= 0;
        retire_cnt <= 0;
        cycle_cnt  <= 0;
        last_retire <= 0;
        prev_stall <= 1'b1;
        loop_entered <= 1'b0;
        lcg_state   = SEED;
        refill_pos  = 0;
        refill_next = '0;
        build_program();
        run_model();
        $display("model: %0d retirements, %0d stores, %0d refills",
                 exp_retire, exp_st_addr.size(), exp_lines.size());
        repeat (5) @(posedge clk);
        check_bit("io_stall in reset", io_stall, 1'b1);
        check_bit("imem_req in reset", imem_req, 1'b0);
        check_bit("dmem_req in reset", dmem_req, 1'b0);
        rst_n <= 1'b1;
        do begin
            @(posedge clk);
            check_bit("io_stall before the first refill", io_stall, 1'b1);
            check_bit("dmem_req before the first refill", dmem_req, 1'b0);
        end while (!imem_req);
        while (!loop_entered) @(posedge clk);
        check_count("stores missing at the final loop", exp_st_addr.size(), 0);
        // the final loop is a resident BEQ with a fixed period
        for (int n = 0; n < 4; n++) begin
            start     = retire_cnt;
            loop_prev = last_retire;
            while (retire_cnt == start) @(posedge clk);
            if (n > 0) begin
                check_count("final loop period", last_retire - loop_prev, LOOP_CYCLES);
            end
        end
        check_count("refills missing at the final loop", exp_lines.size(), 0);
        $display("Regression passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("watchdog timeout after %0d ns with %0d of %0d instructions retired",
                            WATCHDOG_NS, retire_cnt, exp_retire));
    end

endmodule

// ==== build.f ====
+incdir+dv
rtl/cpu_pkg.sv
rtl/cpu_ctrl.sv
rtl/refill_counter.sv
rtl/inst_buffer.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/cpu_top.sv
dv/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the processor testbench

sim:
	verilator --binary --timing --assert -f build.f --top-module cpu_tb -o cpu_tb_sim
	./obj_dir/cpu_tb_sim | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
